// File: include/mul_params.svh
`ifndef MUL_PARAMS_SVH
`define MUL_PARAMS_SVH

// width of each unsigned operand
`define MUL_WIDTH 16

// multiplier bits per lane
// one lane iteration per bit, so this is also the step count
`define MUL_SLICE 8

`endif

// File: list.f
+incdir+include
src/mul_types_pkg.sv
src/mul_ctrl_pkg.sv
src/mul_lane_if.sv
src/mul_controller.sv
src/shift_add_lane.sv
src/product_combiner.sv
src/seq_multiplier_top.sv
test/seq_multiplier_asserts.sv
test/tb_seq_multiplier.sv

// File: run_sim.sh
#!/bin/sh
# build and run the multiplier testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --assert --timing --timescale 1ns/1ps \
    --top-module tb_seq_multiplier -f list.f -o tb_sim \
    && ./obj_dir/tb_sim +verilator+error+limit+100 > sim.log 2>&1 \
    || echo "build or simulation stopped with an error" >> sim.log

cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0

// File: src/mul_controller.sv
`default_nettype none

`include "mul_params.svh"

module mul_controller import mul_ctrl_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    src_valid,
    input  logic    dst_ready,
    input  logic    sum_ready,
    output logic    src_ready,
    output logic    dst_valid,
    output logic    sum_en,
    mul_lane_if.ctrl lo_if,
    mul_lane_if.ctrl hi_if
);

    localparam iter_count_t last_iter = iter_count_t'(`MUL_SLICE - 1);

    ctrl_state_t state;
    ctrl_state_t next_state;
    iter_count_t iter_cnt;
    logic        load;
    logic        step;
    logic        counted;

    // ------------------------------------------------------------
    // state register
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // final lane step happens on this cycle
    assign counted = (state == st_run) && (iter_cnt == last_iter);

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (src_valid) begin
                    next_state = st_run;
                end
            end
            st_run: begin
                if (counted) begin
                    next_state = st_sum;
                end
            end
            st_sum: begin
                if (sum_ready) begin
                    next_state = st_hold;
                end
            end
            st_hold: begin
                if (dst_ready) begin
                    next_state = st_idle;
                end
            end
            default: next_state = st_idle;
        endcase
    end

    // ------------------------------------------------------------
    // iteration counter
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            iter_cnt <= '0;
        end else if (load) begin
            iter_cnt <= '0;
        end else if (step) begin
            iter_cnt <= iter_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------

    assign load      = (state == st_idle) && src_valid;
    assign step      = (state == st_run);
    assign src_ready = (state == st_idle);
    assign dst_valid = (state == st_hold);

    // request the sum until the combiner reports it
    assign sum_en    = (state == st_sum) && !sum_ready;

    assign lo_if.load = load;
    assign lo_if.step = step;
    assign hi_if.load = load;
    assign hi_if.step = step;

endmodule

`default_nettype wire

// File: src/mul_ctrl_pkg.sv
`default_nettype none

`include "mul_params.svh"

package mul_ctrl_pkg;

    // accept, iterate, combine, present
    typedef enum logic [1:0] {
        st_idle = 2'b00,
        st_run  = 2'b01,
        st_sum  = 2'b10,
        st_hold = 2'b11
    } ctrl_state_t;

    // one count per lane step
    typedef logic [$clog2(`MUL_SLICE)-1:0] iter_count_t;

endpackage

`default_nettype wire

// File: src/mul_lane_if.sv
`default_nettype none

interface mul_lane_if import mul_types_pkg::*; ();

    // sequencing from the controller
    logic     load;
    logic     step;

    // operands, driven at the top level
    operand_t multiplicand;
    slice_t   slice;

    // lane results
    partial_t partial;
    logic     lane_done;

    modport ctrl (output load, output step);

    modport lane (input load, input step, input multiplicand, input slice,
                  output partial, output lane_done);

    modport comb (input load, input partial, input lane_done);

endinterface

`default_nettype wire

// File: src/mul_types_pkg.sv
`default_nettype none

`include "mul_params.svh"

package mul_types_pkg;

    // ------------------------------------------------------------
    // datapath types
    // ------------------------------------------------------------

    // one input operand
    typedef logic [`MUL_WIDTH-1:0] operand_t;

    // multiplier bits handled by a single lane
    typedef logic [`MUL_SLICE-1:0] slice_t;

    // full multiplicand times one slice
    typedef logic [`MUL_WIDTH+`MUL_SLICE-1:0] partial_t;

    // final result
    typedef logic [2*`MUL_WIDTH-1:0] product_t;

endpackage

`default_nettype wire

// File: src/product_combiner.sv
`default_nettype none

`include "mul_params.svh"

module product_combiner import mul_types_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     sum_en,
    output logic     sum_ready,
    output product_t product,
    mul_lane_if.comb lo_if,
    mul_lane_if.comb hi_if
);

    logic     take;
    product_t aligned_hi;
    product_t sum;

    // both lanes must be finished
    assign take = sum_en && lo_if.lane_done && hi_if.lane_done;

    // high slice weighs 2**MUL_SLICE
    assign aligned_hi = product_t'(hi_if.partial) << `MUL_SLICE;
    assign sum        = product_t'(lo_if.partial) + aligned_hi;

    // ------------------------------------------------------------
    // result flag
    // ------------------------------------------------------------

    // stays up through hold, dropped when the next operands load
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            sum_ready <= 1'b0;
        end else if (lo_if.load) begin
            sum_ready <= 1'b0;
        end else if (take) begin
            sum_ready <= 1'b1;
        end
    end

    // ------------------------------------------------------------
    // result register
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (take) begin
            product <= sum;
        end
    end

endmodule

`default_nettype wire

// File: src/seq_multiplier_top.sv
`default_nettype none

`include "mul_params.svh"

module seq_multiplier_top import mul_types_pkg::*; (
    input  logic     clk,
    input  logic     reset,

    // operand stream
    input  logic     src_valid,
    input  operand_t src_a,
    input  operand_t src_b,
    output logic     src_ready,

    // product stream
    output logic     dst_valid,
    output product_t dst_product,
    input  logic     dst_ready
);

    logic sum_en;
    logic sum_ready;

    mul_lane_if lo_if ();
    mul_lane_if hi_if ();

    // ------------------------------------------------------------
    // operand distribution
    // ------------------------------------------------------------

    // both lanes see the full multiplicand
    assign lo_if.multiplicand = src_a;
    assign hi_if.multiplicand = src_a;

    assign lo_if.slice = src_b[`MUL_SLICE-1:0];
    assign hi_if.slice = src_b[`MUL_WIDTH-1:`MUL_SLICE];

    // ------------------------------------------------------------
    // blocks
    // ------------------------------------------------------------

    mul_controller u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .src_valid (src_valid),
        .dst_ready (dst_ready),
        .sum_ready (sum_ready),
        .src_ready (src_ready),
        .dst_valid (dst_valid),
        .sum_en    (sum_en),
        .lo_if     (lo_if.ctrl),
        .hi_if     (hi_if.ctrl)
    );

    shift_add_lane u_lane_lo (
        .clk   (clk),
        .reset (reset),
        .lane  (lo_if.lane)
    );

    shift_add_lane u_lane_hi (
        .clk   (clk),
        .reset (reset),
        .lane  (hi_if.lane)
    );

    product_combiner u_comb (
        .clk       (clk),
        .reset     (reset),
        .sum_en    (sum_en),
        .sum_ready (sum_ready),
        .product   (dst_product),
        .lo_if     (lo_if.comb),
        .hi_if     (hi_if.comb)
    );

endmodule

`default_nettype wire

// File: src/shift_add_lane.sv
`default_nettype none

module shift_add_lane import mul_types_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    mul_lane_if.lane lane
);

    partial_t mcand;
    partial_t acc;
    slice_t   mplier;
    slice_t   remain;
    logic     done;
    logic     advance;

    assign advance = lane.step && !done;

    // ------------------------------------------------------------
    // step tracking
    // ------------------------------------------------------------

    // one bit of remain per outstanding step
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            remain <= '0;
            done   <= 1'b0;
        end else if (lane.load) begin
            remain <= '1;
            done   <= 1'b0;
        end else if (advance) begin
            remain <= remain >> 1;
            if (remain == slice_t'(1)) begin
                done <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // shift-add datapath
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (lane.load) begin
            mcand  <= partial_t'(lane.multiplicand);
            mplier <= lane.slice;
            acc    <= '0;
        end else if (advance) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign lane.partial   = acc;
    assign lane.lane_done = done;

endmodule

`default_nettype wire

// File: test/mul_input.txt
// columns in hex: operand a, operand b, expected product, consumer stall cycles
// one operation per line
0000 0000 00000000 0
0000 ffff 00000000 1
ffff 0000 00000000 0
ffff ffff fffe0001 3
0001 0001 00000001 0
ffff 00ff 00feff01 2
ffff ff00 feff0100 0
1234 0001 00001234 4
1234 0100 00123400 1
0001 ffff 0000ffff 0
8000 8000 40000000 5
00ff 00ff 0000fe01 0
abcd 1234 0c374fa4 2
00ff ff00 00fe0100 1
7fff 0002 0000fffe 0
0003 8001 00018003 3

// File: test/seq_multiplier_asserts.sv
`default_nettype none

`include "mul_params.svh"

module seq_multiplier_asserts import mul_types_pkg::*; (
    input logic     clk,
    input logic     reset,
    input logic     src_valid,
    input logic     src_ready,
    input logic     dst_valid,
    input logic     dst_ready,
    input product_t dst_product
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int latency = `MUL_SLICE + 2;

    int   fail_count = 0;
    logic accept;

    assign accept = src_valid && src_ready;

    // ------------------------------------------------------------
    // handshake
    // ------------------------------------------------------------

    // output registered on the tenth edge after accept
    assert property (@(posedge clk) disable iff (!reset)
        accept |-> ##latency !dst_valid ##1 dst_valid)
    else begin
        fail_count++;
        $error("dst_valid did not rise at the expected edge after accept");
    end

    assert property (@(posedge clk) disable iff (!reset)
        dst_valid && !dst_ready |=> dst_valid && $stable(dst_product))
    else begin
        fail_count++;
        $error("product changed or was dropped while stalled");
    end

    // one operation in flight
    assert property (@(posedge clk) disable iff (!reset)
        accept |=> !src_ready)
    else begin
        fail_count++;
        $error("src_ready high right after accept");
    end

    // idle again only once the product is taken
    assert property (@(posedge clk) disable iff (!reset)
        $rose(src_ready) |-> $past(dst_valid && dst_ready))
    else begin
        fail_count++;
        $error("src_ready returned before the product was taken");
    end

endmodule

bind seq_multiplier_top seq_multiplier_asserts u_asserts (
    .clk         (clk),
    .reset       (reset),
    .src_valid   (src_valid),
    .src_ready   (src_ready),
    .dst_valid   (dst_valid),
    .dst_ready   (dst_ready),
    .dst_product (dst_product)
);

`default_nettype wire

// File: test/tb_seq_multiplier.sv
`default_nettype none

`include "mul_params.svh"

module tb_seq_multiplier import mul_types_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_ops = 16;
    localparam int latency = `MUL_SLICE + 2;

    logic     clk;
    logic     reset;
    logic     src_valid;
    operand_t src_a;
    operand_t src_b;
    logic     src_ready;
    logic     dst_valid;
    product_t dst_product;
    logic     dst_ready;

    // four words per operation: a, b, product, stall
    logic [2*`MUL_WIDTH-1:0] op_mem [0:4*num_ops-1];

    int product_errors = 0;
    int flag_errors    = 0;
    int other_errors   = 0;
    int cycle_count    = 0;
    int cycle_limit    = 0;

    seq_multiplier_top UUT (
        .clk         (clk),
        .reset       (reset),
        .src_valid   (src_valid),
        .src_a       (src_a),
        .src_b       (src_b),
        .src_ready   (src_ready),
        .dst_valid   (dst_valid),
        .dst_product (dst_product),
        .dst_ready   (dst_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------
    // checks and reporting
    // ------------------------------------------------------------

    task automatic check_product(input string name, input product_t actual,
                                 input product_t expected);
        if (actual !== expected) begin
            product_errors++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            flag_errors++;
            $display("[ERROR] %0t %s: got %b, expected %b", $time, name, actual, expected);
        end
    endtask

    function automatic int total_errors();
        return product_errors + flag_errors + other_errors + UUT.u_asserts.fail_count;
    endfunction

    task automatic print_summary();
        $display({"summary: %0d product errors, %0d flag errors, %0d other errors, ",
                  "%0d assertion failures"},
                 product_errors, flag_errors, other_errors, UUT.u_asserts.fail_count);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            print_summary();
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // one operation, entered and left just after a falling edge
    // ------------------------------------------------------------

    task automatic run_op(input int idx);
        operand_t a;
        operand_t b;
        product_t expected;
        int       stall;
        int       gap;
        a        = operand_t'(op_mem[4*idx]);
        b        = operand_t'(op_mem[4*idx+1]);
        expected = op_mem[4*idx+2];
        stall    = int'(op_mem[4*idx+3]);
        gap      = int'($urandom % 4);
        if (product_t'(a) * product_t'(b) != expected) begin
            other_errors++;
            $display("data line %0d gives a product that is not a times b", idx);
        end
        repeat (gap) begin
            @(negedge clk);
            check_flag("src_ready", src_ready, 1'b1);
        end
        src_valid = 1'b1;
        src_a     = a;
        src_b     = b;
        check_flag("src_ready", src_ready, 1'b1);
        @(negedge clk);
        // operands are captured, scramble the bus
        src_valid = 1'b0;
        src_a     = operand_t'($urandom);
        src_b     = operand_t'($urandom);
        check_flag("src_ready", src_ready, 1'b0);
        for (int k = 1; k <= latency; k++) begin
            @(negedge clk);
            check_flag("src_ready", src_ready, 1'b0);
            check_flag("dst_valid", dst_valid, k == latency);
        end
        while (!dst_valid) begin
            @(negedge clk);
        end
        check_product("dst_product", dst_product, expected);
        // back-pressure
        for (int s = 0; s < stall; s++) begin
            @(negedge clk);
            check_flag("dst_valid", dst_valid, 1'b1);
            check_flag("src_ready", src_ready, 1'b0);
            check_product("dst_product", dst_product, expected);
        end
        dst_ready = 1'b1;
        @(negedge clk);
        dst_ready = 1'b0;
        check_flag("dst_valid", dst_valid, 1'b0);
        check_flag("src_ready", src_ready, 1'b1);
    endtask

    initial begin
        int stall_total;
        void'($urandom(32'hedaf8d8c));
        reset     = 1'b0;
        src_valid = 1'b0;
        src_a     = '0;
        src_b     = '0;
        dst_ready = 1'b0;
        $readmemh("test/mul_input.txt", op_mem);
        stall_total = 0;
        for (int i = 0; i < num_ops; i++) begin
            stall_total += int'(op_mem[4*i+3]);
        end
        cycle_limit = 20 * num_ops + stall_total + 50;
        repeat (3) @(negedge clk);
        reset = 1'b1;
        @(negedge clk);
        check_flag("src_ready", src_ready, 1'b1);
        check_flag("dst_valid", dst_valid, 1'b0);
        for (int i = 0; i < num_ops; i++) begin
            run_op(i);
        end
        repeat (2) @(negedge clk);
        print_summary();
        if (total_errors() == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
